// ==== include/masku_cfg.svh ====
// Mask unit configuration
`ifndef MASKU_CFG_SVH
`define MASKU_CFG_SVH

////////////////////
// Geometry
////////////////////

// Number of lanes sharing the mask unit
`define MASKU_NR_LANES 4

// Lane datapath width in bits
`define MASKU_ELEN 64

////////////////////
// Field widths
////////////////////

// Vector lengths and element counters
`define MASKU_VL_W 16

// Register-file word address
`define MASKU_ADDR_W 8

// Instruction id
`define MASKU_ID_W 3

// Slots in each per-lane queue
`define MASKU_QUEUE_DEPTH 2

`endif

// ==== logic/masku_pkg.sv ====
// Mask unit shared types
`include "masku_cfg.svh"

package masku_pkg;

  ////////////////////
  // Scalar types
  ////////////////////

  // One lane word and its byte strobe
  typedef logic [`MASKU_ELEN-1:0]   elen_t;
  typedef logic [`MASKU_ELEN/8-1:0] strb_t;

  // Lengths, addresses and ids
  typedef logic [`MASKU_VL_W-1:0]   vlen_t;
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;
  typedef logic [`MASKU_ID_W-1:0]   vid_t;

  // Element width, log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Unit that executes the instruction
  typedef enum logic {
    VFU_ALU  = 1'b0,
    VFU_MASK = 1'b1
  } vfu_e;

  ////////////////////
  // Compound types
  ////////////////////

  // Request from the sequencer
  typedef struct packed {
    vid_t   id;
    vfu_e   vfu;
    logic   vm;    // 1 means unmasked
    vew_e   vsew;
    vlen_t  vl;    // elements, or bits for mask ops
    vaddr_t vd;    // base word address
  } masku_req_t;

  // Full word across all lanes, lane 0 in the low bits
  typedef elen_t [`MASKU_NR_LANES-1:0] lane_word_t;
  typedef strb_t [`MASKU_NR_LANES-1:0] lane_strb_t;

  // Write request toward one lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
  } result_t;

endpackage

// ==== logic/masku_ctrl.sv ====
// Mask unit control
`timescale 1ns/100ps
`include "masku_cfg.svh"

module masku_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Sequencer
  input  masku_pkg::masku_req_t        req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  // Operand handshakes
  input  logic [`MASKU_NR_LANES-1:0]   a_valid_i,
  input  logic [`MASKU_NR_LANES-1:0]   b_valid_i,
  input  logic [`MASKU_NR_LANES-1:0]   m_valid_i,
  output logic [`MASKU_NR_LANES-1:0]   a_ready_o,
  output logic [`MASKU_NR_LANES-1:0]   b_ready_o,
  output logic [`MASKU_NR_LANES-1:0]   m_ready_o,
  // Queue status and pushes
  input  logic                         res_full_i,
  input  logic                         res_retire_i,
  input  logic                         msk_full_i,
  input  logic                         msk_retire_i,
  output logic                         res_push_o,
  output logic                         msk_push_o,
  output logic [`MASKU_NR_LANES-1:0]   msk_lane_valid_o,
  // Datapath controls
  output logic                         vm_o,
  output masku_pkg::vew_e              vsew_o,
  output masku_pkg::vlen_t             remaining_o,
  output masku_pkg::vlen_t             mask_pnt_o,
  output masku_pkg::vaddr_t            addr_o,
  output masku_pkg::vid_t              id_o,
  // Completion
  output logic                         done_o,
  output masku_pkg::vid_t              done_id_o
);
  import masku_pkg::*;

  localparam int unsigned NrLanes  = `MASKU_NR_LANES;
  localparam vlen_t       WordBits = vlen_t'(`MASKU_NR_LANES * `MASKU_ELEN);

  // Held instruction, single slot
  masku_req_t insn_q;
  logic       insn_valid_q, insn_valid_d;
  // Mask elements left to read, result bits left to issue, units left to commit
  vlen_t      read_cnt_q, read_cnt_d;
  vlen_t      issue_cnt_q, issue_cnt_d;
  vlen_t      commit_cnt_q, commit_cnt_d;
  // Bit position inside the current mask word
  vlen_t      mask_pnt_q, mask_pnt_d;
  // Word offset from vd for merges
  vaddr_t     beat_q, beat_d;
  logic       done_d;
  // Elements covered by one lane and by one whole beat
  vlen_t      lane_elems;
  vlen_t      beat_elems;
  logic       take;
  logic       merge_beat;
  logic       dist_beat;

  function automatic vlen_t sat_sub(vlen_t a, vlen_t b);
    return (a > b) ? vlen_t'(a - b) : '0;
  endfunction

  assign lane_elems = vlen_t'(8) >> insn_q.vsew;
  assign beat_elems = vlen_t'(NrLanes * 8) >> insn_q.vsew;

  ////////////////////
  // Handshakes
  ////////////////////

  assign req_ready_o = !insn_valid_q;
  // Unmasked ALU work never needs the mask unit
  assign take = req_valid_i && req_ready_o && !(req_i.vm && req_i.vfu == VFU_ALU);

  // Merge needs A and B everywhere, M only when masked
  assign merge_beat = insn_valid_q && insn_q.vfu == VFU_MASK && issue_cnt_q != '0 &&
                      (&a_valid_i) && (&b_valid_i) && (insn_q.vm || (&m_valid_i)) &&
                      !res_full_i;
  assign dist_beat  = insn_valid_q && insn_q.vfu == VFU_ALU && read_cnt_q != '0 &&
                      (&m_valid_i) && !msk_full_i;

  assign res_push_o = merge_beat;
  assign msk_push_o = dist_beat;

  // Lanes whose first element is past the count get no strobe
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      msk_lane_valid_o[l] = (vlen_t'(l) * lane_elems) < read_cnt_q;
    end
  end

  ////////////////////
  // Counters
  ////////////////////

  always_comb begin
    insn_valid_d = insn_valid_q;
    read_cnt_d   = read_cnt_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    mask_pnt_d   = mask_pnt_q;
    beat_d       = beat_q;
    done_d       = 1'b0;
    a_ready_o    = '0;
    b_ready_o    = '0;
    m_ready_o    = '0;

    // One full word of A, B and M per merge beat
    if (merge_beat) begin
      a_ready_o   = '1;
      b_ready_o   = '1;
      m_ready_o   = {NrLanes{!insn_q.vm}};
      issue_cnt_d = sat_sub(issue_cnt_q, WordBits);
      beat_d      = beat_q + 1'b1;
    end

    // Distribution walks through the mask word
    if (dist_beat) begin
      read_cnt_d = sat_sub(read_cnt_q, beat_elems);
      mask_pnt_d = mask_pnt_q + beat_elems;
      // Word used up, release it to the lanes
      if (mask_pnt_d == WordBits || read_cnt_d == '0) begin
        m_ready_o  = '1;
        mask_pnt_d = '0;
      end
    end

    // Retired slots count toward completion
    if (res_retire_i) begin
      commit_cnt_d = sat_sub(commit_cnt_q, WordBits);
    end
    if (msk_retire_i) begin
      commit_cnt_d = sat_sub(commit_cnt_q, beat_elems);
    end

    if (insn_valid_q && commit_cnt_d == '0) begin
      insn_valid_d = 1'b0;
      done_d       = 1'b1;
    end

    // New instruction, only possible while idle
    if (take) begin
      insn_valid_d = 1'b1;
      read_cnt_d   = req_i.vl;
      issue_cnt_d  = req_i.vl;
      commit_cnt_d = req_i.vl;
      mask_pnt_d   = '0;
      beat_d       = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q       <= '0;
      insn_valid_q <= 1'b0;
      read_cnt_q   <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      mask_pnt_q   <= '0;
      beat_q       <= '0;
      done_o       <= 1'b0;
      done_id_o    <= '0;
    end else begin
      if (take) begin
        insn_q <= req_i;
      end
      insn_valid_q <= insn_valid_d;
      read_cnt_q   <= read_cnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      mask_pnt_q   <= mask_pnt_d;
      beat_q       <= beat_d;
      done_o       <= done_d;
      done_id_o    <= insn_q.id;
    end
  end

  ////////////////////
  // Datapath controls
  ////////////////////

  assign vm_o        = insn_q.vm;
  assign vsew_o      = insn_q.vsew;
  assign remaining_o = (insn_q.vfu == VFU_MASK) ? issue_cnt_q : read_cnt_q;
  assign mask_pnt_o  = mask_pnt_q;
  assign addr_o      = insn_q.vd + beat_q;
  assign id_o        = insn_q.id;

endmodule

// ==== logic/masku_merge_alu.sv ====
// Mask merge ALU
`timescale 1ns/100ps
`include "masku_cfg.svh"

module masku_merge_alu (
  input  masku_pkg::lane_word_t a_i,
  input  masku_pkg::lane_word_t b_i,
  input  masku_pkg::lane_word_t m_i,
  input  logic                  vm_i,
  input  masku_pkg::vlen_t      remaining_i,
  output masku_pkg::lane_word_t result_o
);

  localparam int unsigned NrBits = `MASKU_NR_LANES * `MASKU_ELEN;

  // Flat view, lane l holds bits 64*l upward
  logic [NrBits-1:0] len_en;
  logic [NrBits-1:0] bit_en;

  ////////////////////
  // Bit enable
  ////////////////////

  // Thermometer from the remaining length
  always_comb begin
    for (int i = 0; i < NrBits; i++) begin
      len_en[i] = i < int'(remaining_i);
    end
  end

  // Masked ops also need the M bit
  assign bit_en = vm_i ? len_en : (len_en & m_i);

  ////////////////////
  // Merge
  ////////////////////

  // A where enabled, old destination elsewhere
  assign result_o = (a_i & bit_en) | (b_i & ~bit_en);

endmodule

// ==== logic/masku_mask_expand.sv ====
// Mask bit to byte strobe expander
`timescale 1ns/100ps
`include "masku_cfg.svh"

module masku_mask_expand (
  input  masku_pkg::lane_word_t m_i,
  input  masku_pkg::vew_e       vsew_i,
  input  masku_pkg::vlen_t      mask_pnt_i,
  input  masku_pkg::vlen_t      remaining_i,
  output masku_pkg::lane_strb_t strb_o
);
  import masku_pkg::*;

  localparam int unsigned NrLanes = `MASKU_NR_LANES;
  localparam int unsigned StrbW   = `MASKU_ELEN / 8;
  localparam int unsigned NrBits  = NrLanes * `MASKU_ELEN;
  localparam int unsigned IdxW    = $clog2(NrBits);

  logic [NrBits-1:0] m_flat;
  // Elements held by one lane word at this width
  vlen_t             lane_elems;

  assign m_flat     = m_i;
  assign lane_elems = vlen_t'(StrbW) >> vsew_i;

  ////////////////////
  // Expansion
  ////////////////////

  // Each element covers 1 << vsew bytes of its lane
  always_comb begin
    vlen_t offs;
    vlen_t idx;
    strb_o = '0;
    for (int l = 0; l < NrLanes; l++) begin
      for (int k = 0; k < StrbW; k++) begin
        // Element offset from the current pointer
        offs = vlen_t'(l) * lane_elems + (vlen_t'(k) >> vsew_i);
        idx  = mask_pnt_i + offs;
        // Beyond the count the byte stays off
        strb_o[l][k] = m_flat[idx[IdxW-1:0]] && (offs < remaining_i);
      end
    end
  end

endmodule

// ==== logic/masku_lane_queue.sv ====
// Per-lane slot queue
`timescale 1ns/100ps
`include "masku_cfg.svh"

module masku_lane_queue #(
  parameter type payload_t = logic
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Write side, one slot across all lanes
  input  logic                                push_i,
  input  logic     [`MASKU_NR_LANES-1:0]      push_valid_i,
  input  payload_t [`MASKU_NR_LANES-1:0]      push_data_i,
  // Head slot toward the lanes
  output logic     [`MASKU_NR_LANES-1:0]      head_valid_o,
  output payload_t [`MASKU_NR_LANES-1:0]      head_data_o,
  input  logic     [`MASKU_NR_LANES-1:0]      ack_i,
  // Status
  output logic                                full_o,
  output logic                                retire_o
);

  localparam int unsigned NrLanes = `MASKU_NR_LANES;
  localparam int unsigned Depth   = `MASKU_QUEUE_DEPTH;
  localparam int unsigned PntW    = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW    = $clog2(Depth + 1);

  payload_t [Depth-1:0][NrLanes-1:0] data_q;
  logic     [Depth-1:0][NrLanes-1:0] valid_q;
  logic     [PntW-1:0]               wr_pnt_q;
  logic     [PntW-1:0]               rd_pnt_q;
  logic     [CntW-1:0]               cnt_q;
  // Head lanes still waiting after this cycle's acks
  logic     [NrLanes-1:0]            head_left;

  function automatic logic [PntW-1:0] next_pnt(logic [PntW-1:0] pnt);
    return (pnt == PntW'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  ////////////////////
  // Head and status
  ////////////////////

  assign head_valid_o = valid_q[rd_pnt_q];
  assign head_data_o  = data_q[rd_pnt_q];
  assign head_left    = head_valid_o & ~ack_i;

  assign full_o   = cnt_q == CntW'(Depth);
  // Slot is done once every lane took it
  assign retire_o = (cnt_q != '0) && (head_left == '0);

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (cnt_q != '0) begin
        valid_q[rd_pnt_q] <= head_left;
      end
      // Never the head slot, the caller holds off while full
      if (push_i) begin
        valid_q[wr_pnt_q] <= push_valid_i;
        wr_pnt_q          <= next_pnt(wr_pnt_q);
      end
      if (retire_o) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(retire_o);
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[wr_pnt_q] <= push_data_i;
    end
  end

endmodule

// ==== logic/masku_top.sv ====
// Mask unit top level
`timescale 1ns/100ps
`include "masku_cfg.svh"

module masku_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer
  input  masku_pkg::masku_req_t                       req_i,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  // Operands from the lanes
  input  masku_pkg::lane_word_t                       a_i,
  input  masku_pkg::lane_word_t                       b_i,
  input  masku_pkg::lane_word_t                       m_i,
  input  logic                  [`MASKU_NR_LANES-1:0] a_valid_i,
  input  logic                  [`MASKU_NR_LANES-1:0] b_valid_i,
  input  logic                  [`MASKU_NR_LANES-1:0] m_valid_i,
  output logic                  [`MASKU_NR_LANES-1:0] a_ready_o,
  output logic                  [`MASKU_NR_LANES-1:0] b_ready_o,
  output logic                  [`MASKU_NR_LANES-1:0] m_ready_o,
  // Write requests to the lanes
  output logic                  [`MASKU_NR_LANES-1:0] result_req_o,
  output masku_pkg::vid_t       [`MASKU_NR_LANES-1:0] result_id_o,
  output masku_pkg::vaddr_t     [`MASKU_NR_LANES-1:0] result_addr_o,
  output masku_pkg::lane_word_t                       result_wdata_o,
  input  logic                  [`MASKU_NR_LANES-1:0] result_gnt_i,
  // Byte strobes to the lane ALUs
  output masku_pkg::lane_strb_t                       mask_o,
  output logic                  [`MASKU_NR_LANES-1:0] mask_valid_o,
  input  logic                  [`MASKU_NR_LANES-1:0] mask_ready_i,
  // Completion
  output logic                                        done_o,
  output masku_pkg::vid_t                             done_id_o
);
  import masku_pkg::*;

  localparam int unsigned NrLanes = `MASKU_NR_LANES;

  // Control to datapath
  logic                  vm;
  vew_e                  vsew;
  vlen_t                 remaining;
  vlen_t                 mask_pnt;
  vaddr_t                addr;
  vid_t                  id;
  // Queue handshakes
  logic                  res_full;
  logic                  res_retire;
  logic                  res_push;
  logic                  msk_full;
  logic                  msk_retire;
  logic                  msk_push;
  logic    [NrLanes-1:0] msk_lane_valid;
  // Datapath results
  lane_word_t            alu_result;
  lane_strb_t            msk_strb;
  result_t [NrLanes-1:0] res_push_data;
  result_t [NrLanes-1:0] res_head_data;

  ////////////////////
  // Control
  ////////////////////

  masku_ctrl i_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .a_valid_i        (a_valid_i),
    .b_valid_i        (b_valid_i),
    .m_valid_i        (m_valid_i),
    .a_ready_o        (a_ready_o),
    .b_ready_o        (b_ready_o),
    .m_ready_o        (m_ready_o),
    .res_full_i       (res_full),
    .res_retire_i     (res_retire),
    .msk_full_i       (msk_full),
    .msk_retire_i     (msk_retire),
    .res_push_o       (res_push),
    .msk_push_o       (msk_push),
    .msk_lane_valid_o (msk_lane_valid),
    .vm_o             (vm),
    .vsew_o           (vsew),
    .remaining_o      (remaining),
    .mask_pnt_o       (mask_pnt),
    .addr_o           (addr),
    .id_o             (id),
    .done_o           (done_o),
    .done_id_o        (done_id_o)
  );

  ////////////////////
  // Datapath
  ////////////////////

  masku_merge_alu i_merge_alu (
    .a_i         (a_i),
    .b_i         (b_i),
    .m_i         (m_i),
    .vm_i        (vm),
    .remaining_i (remaining),
    .result_o    (alu_result)
  );

  masku_mask_expand i_mask_expand (
    .m_i         (m_i),
    .vsew_i      (vsew),
    .mask_pnt_i  (mask_pnt),
    .remaining_i (remaining),
    .strb_o      (msk_strb)
  );

  // Pack and unpack one write request per lane
  for (genvar l = 0; l < NrLanes; l++) begin : gen_result_lane
    assign res_push_data[l]  = '{id: id, addr: addr, wdata: alu_result[l]};
    assign result_id_o[l]    = res_head_data[l].id;
    assign result_addr_o[l]  = res_head_data[l].addr;
    assign result_wdata_o[l] = res_head_data[l].wdata;
  end

  ////////////////////
  // Queues
  ////////////////////

  // Every lane gets a full word on each merge beat
  masku_lane_queue #(
    .payload_t (result_t)
  ) i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (res_push),
    .push_valid_i ({NrLanes{1'b1}}),
    .push_data_i  (res_push_data),
    .head_valid_o (result_req_o),
    .head_data_o  (res_head_data),
    .ack_i        (result_gnt_i),
    .full_o       (res_full),
    .retire_o     (res_retire)
  );

  masku_lane_queue #(
    .payload_t (strb_t)
  ) i_mask_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (msk_push),
    .push_valid_i (msk_lane_valid),
    .push_data_i  (msk_strb),
    .head_valid_o (mask_valid_o),
    .head_data_o  (mask_o),
    .ack_i        (mask_ready_i),
    .full_o       (msk_full),
    .retire_o     (msk_retire)
  );

endmodule

// ==== verif/tb_masku.sv ====
// Mask unit testbench
`timescale 1ns/100ps
`include "masku_cfg.svh"

module tb_masku;
  import masku_pkg::*;

  localparam int NrLanes        = `MASKU_NR_LANES;
  localparam int NrBits         = `MASKU_NR_LANES * `MASKU_ELEN;
  localparam int MaxBeats       = 4;
  localparam int ReqTimeout     = 20;
  localparam int OperandTimeout = 200;
  localparam int DoneTimeout    = 100;
  // Beats per test: 1 + 3 + (1+2+3+5) + 4 + 2
  localparam int TotalBeats     = 21;
  localparam int WatchdogCycles = TotalBeats * 50;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  masku_req_t            req_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  lane_word_t            a_i;
  lane_word_t            b_i;
  lane_word_t            m_i;
  logic    [NrLanes-1:0] a_valid_i;
  logic    [NrLanes-1:0] b_valid_i;
  logic    [NrLanes-1:0] m_valid_i;
  logic    [NrLanes-1:0] a_ready_o;
  logic    [NrLanes-1:0] b_ready_o;
  logic    [NrLanes-1:0] m_ready_o;
  logic    [NrLanes-1:0] result_req_o;
  vid_t    [NrLanes-1:0] result_id_o;
  vaddr_t  [NrLanes-1:0] result_addr_o;
  lane_word_t            result_wdata_o;
  logic    [NrLanes-1:0] result_gnt_i;
  lane_strb_t            mask_o;
  logic    [NrLanes-1:0] mask_valid_o;
  logic    [NrLanes-1:0] mask_ready_i;
  logic                  done_o;
  vid_t                  done_id_o;

  // Operand words for each beat of the running merge
  lane_word_t a_beats [MaxBeats];
  lane_word_t b_beats [MaxBeats];
  lane_word_t m_beats [MaxBeats];
  // Transfers seen at the lane side
  result_t              res_log[$];
  int                   res_lane_log[$];
  logic   [NrLanes-1:0] msk_vld_log[$];
  lane_strb_t           msk_strb_log[$];

  logic [31:0] rng_state = 32'hc89baf4b;
  int          tests  = 0;
  int          checks = 0;
  int          errors = 0;

  masku_top i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .a_i            (a_i),
    .b_i            (b_i),
    .m_i            (m_i),
    .a_valid_i      (a_valid_i),
    .b_valid_i      (b_valid_i),
    .m_valid_i      (m_valid_i),
    .a_ready_o      (a_ready_o),
    .b_ready_o      (b_ready_o),
    .m_ready_o      (m_ready_o),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_gnt_i   (result_gnt_i),
    .mask_o         (mask_o),
    .mask_valid_o   (mask_valid_o),
    .mask_ready_i   (mask_ready_i),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  ////////////////////
  // Lane monitor
  ////////////////////

  // Values read at the edge are the ones the DUT sampled
  always @(posedge clk_i) begin : lane_monitor
    result_t seen;
    if (rst_ni) begin
      for (int l = 0; l < NrLanes; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          seen.id    = result_id_o[l];
          seen.addr  = result_addr_o[l];
          seen.wdata = result_wdata_o[l];
          res_log.push_back(seen);
          res_lane_log.push_back(l);
        end
      end
      if (|(mask_valid_o & mask_ready_i)) begin
        msk_vld_log.push_back(mask_valid_o);
        msk_strb_log.push_back(mask_o);
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic elen_t rand_word();
    elen_t w;
    rng_state  = xorshift32(rng_state);
    w[31:0]    = rng_state;
    rng_state  = xorshift32(rng_state);
    w[63:32]   = rng_state;
    return w;
  endfunction

  // Reference merge, A below the length where enabled, else B
  function automatic lane_word_t merged_word(lane_word_t a, lane_word_t b, lane_word_t m,
                                             logic vm, int left);
    logic [NrBits-1:0] fa;
    logic [NrBits-1:0] fb;
    logic [NrBits-1:0] fm;
    logic [NrBits-1:0] fr;
    fa = a;
    fb = b;
    fm = m;
    for (int i = 0; i < NrBits; i++) begin
      fr[i] = (i < left && (vm || fm[i])) ? fa[i] : fb[i];
    end
    return fr;
  endfunction

  // Reference strobe of one lane, element width is 1 << sew bytes
  function automatic strb_t strobe_for(lane_word_t m, int sew, int pnt, int left, int lane);
    logic [NrBits-1:0] fm;
    strb_t             s;
    int                elem;
    fm = m;
    for (int k = 0; k < 8; k++) begin
      elem = lane * (8 >> sew) + (k >> sew);
      s[k] = (elem < left) ? fm[pnt + elem] : 1'b0;
    end
    return s;
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - start);
    end
  endtask

  task automatic clear_logs();
    res_log.delete();
    res_lane_log.delete();
    msk_vld_log.delete();
    msk_strb_log.delete();
  endtask

  task automatic fill_beats(input int nbeats);
    for (int j = 0; j < nbeats; j++) begin
      for (int l = 0; l < NrLanes; l++) begin
        a_beats[j][l] = rand_word();
        b_beats[j][l] = rand_word();
        m_beats[j][l] = rand_word();
      end
    end
  endtask

  ////////////////////
  // Lane drivers
  ////////////////////

  task automatic send_req(input masku_req_t req, output logic ok);
    int waited;
    ok     = 1'b0;
    waited = 0;
    req_i       <= req;
    req_valid_i <= 1'b1;
    while (!ok && waited < ReqTimeout) begin
      @(posedge clk_i);
      waited++;
      ok = req_ready_o;
    end
    req_valid_i <= 1'b0;
    require(ok, $sformatf("request with id %0d was never accepted", req.id));
  endtask

  // One full word of A, B and M per beat, next word after the readies
  task automatic drive_merge_beats(input int nbeats, input logic use_m);
    int taken;
    int waited;
    taken  = 0;
    waited = 0;
    a_i       <= a_beats[0];
    b_i       <= b_beats[0];
    m_i       <= m_beats[0];
    a_valid_i <= '1;
    b_valid_i <= '1;
    m_valid_i <= {NrLanes{use_m}};
    while (taken < nbeats && waited < OperandTimeout) begin
      @(posedge clk_i);
      waited++;
      if (&a_ready_o) begin
        expect_eq("b_ready_o", b_ready_o, {NrLanes{1'b1}});
        expect_eq("m_ready_o", m_ready_o, {NrLanes{use_m}});
        taken++;
        if (taken < nbeats) begin
          a_i <= a_beats[taken];
          b_i <= b_beats[taken];
          m_i <= m_beats[taken];
        end
      end
    end
    a_valid_i <= '0;
    b_valid_i <= '0;
    m_valid_i <= '0;
    require(taken == nbeats, $sformatf("only %0d of %0d merge beats were taken", taken, nbeats));
  endtask

  // Mask word stays up until the unit releases it
  task automatic drive_mask_word(input lane_word_t m);
    int   waited;
    logic used;
    waited = 0;
    used   = 1'b0;
    m_i       <= m;
    m_valid_i <= '1;
    while (!used && waited < OperandTimeout) begin
      @(posedge clk_i);
      waited++;
      used = &m_ready_o;
    end
    m_valid_i <= '0;
    require(used, "mask word was never released by m_ready_o");
  endtask

  task automatic wait_done(input vid_t id);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < DoneTimeout) begin
      @(posedge clk_i);
      waited++;
      seen = done_o;
    end
    require(seen, $sformatf("no done_o within %0d cycles for id %0d", DoneTimeout, id));
    if (seen) begin
      expect_eq("done_id_o", done_id_o, id);
    end
  endtask

  // Writes arrive beat by beat, lanes in order within a beat
  task automatic check_merge_log(input masku_req_t req, input int nbeats);
    lane_word_t exp_word;
    int         beat;
    int         lane;
    require(res_log.size() == nbeats * NrLanes,
            $sformatf("expected %0d result writes, saw %0d", nbeats * NrLanes, res_log.size()));
    for (int e = 0; e < res_log.size() && e < nbeats * NrLanes; e++) begin
      beat     = e / NrLanes;
      lane     = e % NrLanes;
      exp_word = merged_word(a_beats[beat], b_beats[beat], m_beats[beat], req.vm,
                             int'(req.vl) - beat * NrBits);
      expect_eq("result lane", res_lane_log[e], lane);
      expect_eq($sformatf("result_addr_o[%0d]", lane), res_log[e].addr, vaddr_t'(req.vd + beat));
      expect_eq($sformatf("result_id_o[%0d]", lane), res_log[e].id, req.id);
      expect_eq($sformatf("result_wdata_o[%0d]", lane), res_log[e].wdata, exp_word[lane]);
    end
  endtask

  task automatic run_merge(input masku_req_t req);
    int   nbeats;
    logic ok;
    nbeats = (int'(req.vl) + NrBits - 1) / NrBits;
    clear_logs();
    fill_beats(nbeats);
    send_req(req, ok);
    if (ok) begin
      drive_merge_beats(nbeats, !req.vm);
      wait_done(req.id);
    end
    check_merge_log(req, nbeats);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_values();
    int start;
    start = errors;
    expect_eq("req_ready_o", req_ready_o, 1);
    expect_eq("a_ready_o", a_ready_o, 0);
    expect_eq("b_ready_o", b_ready_o, 0);
    expect_eq("m_ready_o", m_ready_o, 0);
    expect_eq("result_req_o", result_req_o, 0);
    expect_eq("mask_valid_o", mask_valid_o, 0);
    expect_eq("done_o", done_o, 0);
    report_test("reset_values", start);
  endtask

  task automatic merge_unmasked();
    int start;
    start = errors;
    run_merge('{id: 3'd1, vfu: VFU_MASK, vm: 1'b1, vsew: EW8, vl: 16'd100, vd: 8'h10});
    report_test("merge_unmasked", start);
  endtask

  task automatic merge_masked();
    int start;
    start = errors;
    // Three beats, addresses vd to vd+2
    run_merge('{id: 3'd2, vfu: VFU_MASK, vm: 1'b0, vsew: EW8, vl: 16'd600, vd: 8'h30});
    report_test("merge_masked", start);
  endtask

  task automatic distribute_one(input vew_e sew, input vid_t id);
    masku_req_t           req;
    lane_word_t           m;
    logic                 ok;
    logic   [NrLanes-1:0] vld_exp;
    int                   per_beat;
    int                   nbeats;
    int                   left;
    clear_logs();
    for (int l = 0; l < NrLanes; l++) begin
      m[l] = rand_word();
    end
    req = '{id: id, vfu: VFU_ALU, vm: 1'b0, vsew: sew, vl: 16'd20, vd: 8'h00};
    send_req(req, ok);
    if (ok) begin
      drive_mask_word(m);
      wait_done(id);
    end
    // Elements per beat across all lanes
    per_beat = 32 >> int'(sew);
    nbeats   = (20 + per_beat - 1) / per_beat;
    require(msk_vld_log.size() == nbeats,
            $sformatf("EW%0d expected %0d mask slots, saw %0d", 8 << int'(sew), nbeats,
                      msk_vld_log.size()));
    for (int j = 0; j < nbeats && j < msk_vld_log.size(); j++) begin
      left = 20 - j * per_beat;
      for (int l = 0; l < NrLanes; l++) begin
        vld_exp[l] = l * (8 >> int'(sew)) < left;
      end
      expect_eq("mask_valid_o", msk_vld_log[j], vld_exp);
      for (int l = 0; l < NrLanes; l++) begin
        if (vld_exp[l]) begin
          expect_eq($sformatf("mask_o[%0d]", l), msk_strb_log[j][l],
                    strobe_for(m, int'(sew), j * per_beat, left, l));
        end
      end
    end
  endtask

  task automatic distribute_widths();
    int start;
    start = errors;
    for (int w = 0; w < 4; w++) begin
      distribute_one(vew_e'(w), vid_t'(3 + w));
    end
    report_test("distribute_widths", start);
  endtask

  task automatic result_backpressure();
    masku_req_t req;
    logic       ok;
    int         start;
    int         beats_seen;
    int         waited;
    start = errors;
    req   = '{id: 3'd4, vfu: VFU_MASK, vm: 1'b1, vsew: EW8, vl: 16'd1024, vd: 8'h80};
    clear_logs();
    fill_beats(4);
    result_gnt_i <= '0;
    send_req(req, ok);
    if (ok) begin
      fork
        drive_merge_beats(4, 1'b0);
        begin
          beats_seen = 0;
          waited     = 0;
          while (beats_seen < 2 && waited < OperandTimeout) begin
            @(posedge clk_i);
            waited++;
            if (&a_ready_o) begin
              beats_seen++;
            end
          end
          // Both slots are full, so nothing more may be taken
          repeat (10) begin
            @(posedge clk_i);
            expect_eq("a_ready_o", a_ready_o, 0);
            expect_eq("result_req_o", result_req_o, {NrLanes{1'b1}});
            // Head slot still holds the first beat
            for (int l = 0; l < NrLanes; l++) begin
              expect_eq($sformatf("result_addr_o[%0d]", l), result_addr_o[l], req.vd);
            end
          end
          result_gnt_i <= '1;
        end
      join
      wait_done(req.id);
    end
    result_gnt_i <= '1;
    check_merge_log(req, 4);
    report_test("result_backpressure", start);
  endtask

  task automatic ignored_alu_request();
    logic ok;
    int   start;
    start = errors;
    clear_logs();
    send_req('{id: 3'd6, vfu: VFU_ALU, vm: 1'b1, vsew: EW32, vl: 16'd40, vd: 8'h20}, ok);
    // Unit stays idle and free
    repeat (12) begin
      @(posedge clk_i);
      require(!done_o, "done_o pulsed for an ignored request");
      expect_eq("req_ready_o", req_ready_o, 1);
      expect_eq("result_req_o", result_req_o, 0);
      expect_eq("mask_valid_o", mask_valid_o, 0);
    end
    run_merge('{id: 3'd5, vfu: VFU_MASK, vm: 1'b1, vsew: EW8, vl: 16'd64, vd: 8'h40});
    report_test("ignored_alu_request", start);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    rst_ni       = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    a_i          = '0;
    b_i          = '0;
    m_i          = '0;
    a_valid_i    = '0;
    b_valid_i    = '0;
    m_valid_i    = '0;
    result_gnt_i = '1;
    mask_ready_i = '1;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    reset_values();
    merge_unmasked();
    merge_masked();
    distribute_widths();
    result_backpressure();
    ignored_alu_request();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
logic/masku_pkg.sv
logic/masku_ctrl.sv
logic/masku_merge_alu.sv
logic/masku_mask_expand.sv
logic/masku_lane_queue.sv
logic/masku_top.sv
verif/tb_masku.sv

// ==== Bender.yml ====
package:
  name: masku

export_include_dirs:
  - include

sources:
  - logic/masku_pkg.sv
  - logic/masku_ctrl.sv
  - logic/masku_merge_alu.sv
  - logic/masku_mask_expand.sv
  - logic/masku_lane_queue.sv
  - logic/masku_top.sv
  - target: test
    files:
      - verif/tb_masku.sv
